//--- project.f
+incdir+source
source/cp0Pkg.sv
source/cp0WbSlave.sv
source/cp0Regs.sv
source/tlbArray.sv
source/exceptionUnit.sv
source/cp0Subsystem.sv
test/cp0_sva.sv
test/cp0Tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module cp0Tb -o cp0Sim \
    || { echo "Compile failed"; exit 1; }

./obj_dir/cp0Sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- source/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    typedef logic [31:0] word_t;     // Data word, PC, bus data.
    typedef logic [7:0]  cp0Addr_t;  // Register number and select.
    typedef logic [4:0]  excCode_t;  // Cause.ExcCode.
    typedef logic [3:0]  tlbIdx_t;   // TLB entry number.

    typedef enum logic [1:0] {
        tlbNone,
        tlbProbe,
        tlbRead,
        tlbWriteIndexed
    } tlbCmd_t;

    typedef enum logic {
        excIdle,
        excRedirect
    } excState_t;

endpackage

`default_nettype wire

//--- source/cp0Regs.sv
`default_nettype none

`include "cp0_consts.svh"

module cp0Regs import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic [5:0] interrupt,
    input  logic     rdEna,
    input  logic     wrEna,
    input  cp0Addr_t addr,
    input  word_t    wrData,
    output word_t    rdData,
    input  logic     updEna,
    input  excCode_t updCode,
    input  logic     updBd,
    input  word_t    updEpc,
    input  logic     updBadVAddrEna,
    input  word_t    updBadVAddr,
    input  logic     updEntryHiEna,
    input  logic     clearExl,
    input  logic     probeEna,
    input  word_t    probeIndex,
    input  logic     readEna,
    input  word_t    readEntryHi,
    input  word_t    readEntryLo0,
    input  word_t    readEntryLo1,
    output word_t    epc,
    output word_t    index,
    output word_t    entryHi,
    output word_t    entryLo0,
    output word_t    entryLo1,
    output logic     exl,
    output logic     hasInt
);

    logic [32:0] count;  // Upper 32 bits are architectural.
    word_t       compare;
    word_t       status;
    word_t       cause;
    word_t       badVAddr;
    word_t       configWord;

    assign exl    = status[1];
    assign hasInt = (|(cause[15:8] & status[15:8])) & status[0] & ~status[1];

    // ######################################################################
    // Control registers.
    // ######################################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            status     <= `STATUS_RESET;
            cause      <= '0;
            count      <= '0;
            compare    <= '0;
            index      <= '0;
            entryHi    <= '0;
            configWord <= `CONFIG_RESET;
        end else begin
            count        <= count + 33'd1;
            cause[15:10] <= {cause[30] | interrupt[5], interrupt[4:0]};  // TI joins IP7.

            if (compare != '0 && count[32:1] == compare) begin
                cause[30] <= 1'b1;
            end

            if (wrEna) begin
                case (addr)
                    `CP0_INDEX:   index <= wrData & `INDEX_WMASK;
                    `CP0_COUNT:   count <= {wrData, 1'b0};
                    `CP0_ENTRYHI: entryHi <= wrData & `ENTRYHI_WMASK;
                    `CP0_COMPARE: begin
                        compare   <= wrData;
                        cause[30] <= 1'b0;  // Acknowledge timer.
                    end
                    `CP0_STATUS:  status <= (status & ~`STATUS_WMASK) | (wrData & `STATUS_WMASK);
                    `CP0_CAUSE:   cause[9:8] <= wrData[9:8];  // Software IP only.
                    `CP0_CONFIG:  configWord[2:0] <= wrData[2:0];
                    default:      ;
                endcase
            end

            if (clearExl) begin
                status[1] <= 1'b0;
            end

            // Hardware events win over a software write in the same cycle.
            if (updEna) begin
                cause[6:2] <= updCode;
                cause[31]  <= updBd;
                status[1]  <= 1'b1;
            end

            if (updEntryHiEna) begin
                entryHi[31:13] <= updBadVAddr[31:13];  // VPN2 of the fault.
            end

            if (probeEna) begin
                index <= probeIndex;
            end

            if (readEna) begin
                entryHi <= readEntryHi;
            end
        end
    end

    // ######################################################################
    // Data registers.
    // ######################################################################
    always_ff @(posedge clk) begin
        if (wrEna && addr == `CP0_EPC) begin
            epc <= wrData;
        end
        if (updEna) begin
            epc <= updEpc;
        end
        if (updBadVAddrEna) begin
            badVAddr <= updBadVAddr;
        end
        if (wrEna && addr == `CP0_ENTRYLO0) begin
            entryLo0 <= wrData & `ENTRYLO_WMASK;
        end
        if (wrEna && addr == `CP0_ENTRYLO1) begin
            entryLo1 <= wrData & `ENTRYLO_WMASK;
        end
        if (readEna) begin
            entryLo0 <= readEntryLo0;
            entryLo1 <= readEntryLo1;
        end
    end

    always_comb begin
        rdData = '0;
        if (rdEna) begin
            case (addr)
                `CP0_INDEX:    rdData = index;
                `CP0_ENTRYLO0: rdData = entryLo0;
                `CP0_ENTRYLO1: rdData = entryLo1;
                `CP0_BADVADDR: rdData = badVAddr;
                `CP0_COUNT:    rdData = count[32:1];
                `CP0_ENTRYHI:  rdData = entryHi;
                `CP0_COMPARE:  rdData = compare;
                `CP0_STATUS:   rdData = status;
                `CP0_CAUSE:    rdData = cause;
                `CP0_EPC:      rdData = epc;
                `CP0_CONFIG:   rdData = configWord;
                `CP0_CONFIG1:  rdData = `CONFIG1_RESET;  // Read only.
                default:       rdData = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/cp0Subsystem.sv
`default_nettype none

module cp0Subsystem import cp0Pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       wbCyc,
    input  logic       wbStb,
    input  logic       wbWe,
    input  cp0Addr_t   wbAdr,
    input  word_t      wbDatW,
    output word_t      wbDatR,
    output logic       wbAck,
    input  logic [5:0] interrupt,
    input  tlbCmd_t    tlbCmd,
    input  logic       excValid,
    input  excCode_t   excCode,
    input  word_t      excPc,
    input  logic       excInSlot,
    input  logic       excBadVAddrValid,
    input  word_t      excBadVAddr,
    input  logic       eret,
    input  logic       instrValid,
    input  word_t      instrPc,
    input  logic       instrInSlot,
    output logic       redirectValid,
    output word_t      redirectPc
);

    logic     rdEna, wrEna;
    cp0Addr_t addr;
    word_t    wrData, rdData;
    word_t    epc, index, entryHi, entryLo0, entryLo1;
    logic     exl, hasInt;
    logic     updEna, updBd, updBadVAddrEna, updEntryHiEna, clearExl;
    excCode_t updCode;
    word_t    updEpc, updBadVAddr;
    logic     probeEna, readEna;
    word_t    probeIndex, readEntryHi, readEntryLo0, readEntryLo1;

    cp0WbSlave wbSlave (.*);

    cp0Regs regs (.*);

    tlbArray tlb (.*);

    exceptionUnit excUnit (.*);

endmodule

`default_nettype wire

//--- source/cp0WbSlave.sv
`default_nettype none

module cp0WbSlave import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  cp0Addr_t wbAdr,
    input  word_t    wbDatW,
    output word_t    wbDatR,
    output logic     wbAck,
    output logic     rdEna,
    output logic     wrEna,
    output cp0Addr_t addr,
    output word_t    wrData,
    input  word_t    rdData
);

    logic reqNew;

    // Ack in the following cycle masks the held request.
    assign reqNew = wbCyc & wbStb & ~wbAck;
    assign rdEna  = reqNew & ~wbWe;
    assign wrEna  = reqNew & wbWe;
    assign addr   = wbAdr;
    assign wrData = wbDatW;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= reqNew;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEna) begin
            wbDatR <= rdData;  // Valid while ack is high.
        end
    end

endmodule

`default_nettype wire

//--- source/cp0_consts.svh
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// ##########################################################################
// Register addresses as register number times eight plus select.
// ##########################################################################
`define CP0_INDEX     8'h00
`define CP0_ENTRYLO0  8'h10
`define CP0_ENTRYLO1  8'h18
`define CP0_BADVADDR  8'h40
`define CP0_COUNT     8'h48
`define CP0_ENTRYHI   8'h50
`define CP0_COMPARE   8'h58
`define CP0_STATUS    8'h60
`define CP0_CAUSE     8'h68
`define CP0_EPC       8'h70
`define CP0_CONFIG    8'h80
`define CP0_CONFIG1   8'h81

// ##########################################################################
// Reset words and software write masks.
// ##########################################################################
`define STATUS_RESET  32'h0040_0000  // BEV only.
`define CONFIG_RESET  32'h8000_0083  // M set, MT=1, K0 cached.
`define CONFIG1_RESET 32'h2099_4C80
`define STATUS_WMASK  32'h0000_FF03  // IM, EXL, IE.
`define ENTRYHI_WMASK 32'hFFFF_E0FF
`define ENTRYLO_WMASK 32'h03FF_FFFF
`define INDEX_WMASK   32'h0000_000F

// ##########################################################################
// TLB and exceptions.
// ##########################################################################
`define TLB_ENTRIES   16
`define EXC_VECTOR    32'hBFC0_0380
`define EXC_INT       5'd0
`define EXC_TLBL      5'd2
`define EXC_TLBS      5'd3

`endif

//--- source/exceptionUnit.sv
`default_nettype none

`include "cp0_consts.svh"

module exceptionUnit import cp0Pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     excValid,
    input  excCode_t excCode,
    input  word_t    excPc,
    input  logic     excInSlot,
    input  logic     excBadVAddrValid,
    input  word_t    excBadVAddr,
    input  logic     eret,
    input  logic     instrValid,
    input  word_t    instrPc,
    input  logic     instrInSlot,
    input  logic     hasInt,
    input  logic     exl,
    input  word_t    epc,
    output logic     updEna,
    output excCode_t updCode,
    output logic     updBd,
    output word_t    updEpc,
    output logic     updBadVAddrEna,
    output word_t    updBadVAddr,
    output logic     updEntryHiEna,
    output logic     clearExl,
    output logic     redirectValid,
    output word_t    redirectPc
);

    excState_t state;
    logic      idleNow;
    logic      takeInt;
    logic      takeExc;
    logic      takeEret;
    word_t     evPc;

    assign idleNow  = (state == excIdle);
    assign takeInt  = idleNow & hasInt & instrValid;
    assign takeExc  = idleNow & ~takeInt & excValid & ~exl;  // No nesting.
    assign takeEret = idleNow & ~takeInt & ~takeExc & eret;

    assign evPc           = takeInt ? instrPc : excPc;
    assign updBd          = takeInt ? instrInSlot : excInSlot;
    assign updEna         = takeInt | takeExc;
    assign updCode        = takeInt ? `EXC_INT : excCode;
    assign updEpc         = updBd ? evPc - 32'd4 : evPc;  // Point at the branch.
    assign updBadVAddrEna = takeExc & excBadVAddrValid;
    assign updBadVAddr    = excBadVAddr;
    assign updEntryHiEna  = updBadVAddrEna & (excCode == `EXC_TLBL || excCode == `EXC_TLBS);
    assign clearExl       = takeEret;
    assign redirectValid  = (state == excRedirect);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= excIdle;
        end else begin
            case (state)
                excIdle:     if (updEna || takeEret) state <= excRedirect;
                excRedirect: state <= excIdle;  // One cycle pulse.
                default:     state <= excIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (updEna) begin
            redirectPc <= `EXC_VECTOR;
        end else if (takeEret) begin
            redirectPc <= epc;
        end
    end

endmodule

`default_nettype wire

//--- source/tlbArray.sv
`default_nettype none

`include "cp0_consts.svh"

module tlbArray import cp0Pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  tlbCmd_t tlbCmd,
    input  word_t   index,
    input  word_t   entryHi,
    input  word_t   entryLo0,
    input  word_t   entryLo1,
    output logic    probeEna,
    output word_t   probeIndex,
    output logic    readEna,
    output word_t   readEntryHi,
    output word_t   readEntryLo0,
    output word_t   readEntryLo1
);

    logic [18:0] vpn2 [`TLB_ENTRIES];
    logic [7:0]  asid [`TLB_ENTRIES];
    logic        gBit [`TLB_ENTRIES];
    logic [24:0] lo0  [`TLB_ENTRIES];  // PFN, C, D, V.
    logic [24:0] lo1  [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] valid;
    logic [`TLB_ENTRIES-1:0] match;
    logic    hit;
    tlbIdx_t hitIdx;
    tlbIdx_t sel;

    assign sel = index[3:0];

    always_ff @(posedge clk) begin
        if (tlbCmd == tlbWriteIndexed) begin
            vpn2[sel] <= entryHi[31:13];
            asid[sel] <= entryHi[7:0];
            gBit[sel] <= entryLo0[0] & entryLo1[0];  // Global only if both halves say so.
            lo0[sel]  <= entryLo0[25:1];
            lo1[sel]  <= entryLo1[25:1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (tlbCmd == tlbWriteIndexed) begin
            valid[sel] <= 1'b1;
        end
    end

    // ######################################################################
    // Probe.
    // ######################################################################
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = valid[i] && vpn2[i] == entryHi[31:13] &&
                       (gBit[i] || asid[i] == entryHi[7:0]);
        end
    end

    // Lowest index wins, so scan downwards.
    always_comb begin
        hit    = 1'b0;
        hitIdx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit    = 1'b1;
                hitIdx = tlbIdx_t'(i);
            end
        end
    end

    assign probeEna   = (tlbCmd == tlbProbe);
    assign probeIndex = hit ? {28'd0, hitIdx} : 32'h8000_0000;  // P bit on miss.

    // ######################################################################
    // Indexed read.
    // ######################################################################
    assign readEna      = (tlbCmd == tlbRead);
    assign readEntryHi  = valid[sel] ? {vpn2[sel], 5'd0, asid[sel]} : '0;
    assign readEntryLo0 = valid[sel] ? {6'd0, lo0[sel], gBit[sel]} : '0;
    assign readEntryLo1 = valid[sel] ? {6'd0, lo1[sel], gBit[sel]} : '0;

endmodule

`default_nettype wire

//--- test/cp0Tb.sv
`default_nettype none

`include "cp0_consts.svh"

module cp0Tb import cp0Pkg::*; ();

    localparam int resetCycles    = 3;
    localparam int maskCycles     = 40;
    localparam int tlbCycles      = 120;
    localparam int excCycles      = 40;
    localparam int intCycles      = 80;
    localparam int timerCycles    = 90;
    localparam int watchdogCycles =
        2 * (resetCycles + maskCycles + tlbCycles + excCycles + intCycles + timerCycles);

    logic       clk;
    logic       rst;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    cp0Addr_t   wbAdr;
    word_t      wbDatW;
    word_t      wbDatR;
    logic       wbAck;
    logic [5:0] interrupt;
    tlbCmd_t    tlbCmd;
    logic       excValid;
    excCode_t   excCode;
    word_t      excPc;
    logic       excInSlot;
    logic       excBadVAddrValid;
    word_t      excBadVAddr;
    logic       eret;
    logic       instrValid;
    word_t      instrPc;
    logic       instrInSlot;
    logic       redirectValid;
    word_t      redirectPc;
    integer     seed;

    word_t modelHi  [3];  // Expected TLB contents.
    word_t modelLo0 [3];
    word_t modelLo1 [3];

    cp0Subsystem dut (.*);

    always #5 clk = ~clk;

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ##########################################################################
    // Wishbone master.
    // ##########################################################################
    task automatic waitAck();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!wbAck && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!wbAck) begin
            $display("The Wishbone slave never answered the request with an ack");
            $display("Something failed");
            $fatal(1, "bus timeout");
        end
    endtask

    task automatic wbWrite(input cp0Addr_t adr, input word_t data);
        @(negedge clk);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatW = data;
        waitAck();
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbRead(input cp0Addr_t adr, output word_t data);
        @(negedge clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        waitAck();
        data  = wbDatR;  // Registered, valid with ack.
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    task automatic readExpect(input string name, input cp0Addr_t adr, input word_t expected);
        word_t value;
        wbRead(adr, value);
        check(name, value, expected);
    endtask

    // ##########################################################################
    // Pipeline side.
    // ##########################################################################
    task automatic clearPipeline();
        excValid         = 1'b0;
        excInSlot        = 1'b0;
        excBadVAddrValid = 1'b0;
        eret             = 1'b0;
        instrValid       = 1'b0;
        instrInSlot      = 1'b0;
    endtask

    task automatic tlbOp(input tlbCmd_t cmd);
        @(negedge clk);
        tlbCmd = cmd;
        @(negedge clk);
        tlbCmd = tlbNone;
    endtask

    task automatic raiseExc(input excCode_t code, input word_t pc, input logic inSlot,
                            input logic badValid, input word_t bad);
        @(negedge clk);
        excValid         = 1'b1;
        excCode          = code;
        excPc            = pc;
        excInSlot        = inSlot;
        excBadVAddrValid = badValid;
        excBadVAddr      = bad;
    endtask

    task automatic doEret();
        @(negedge clk);
        eret = 1'b1;
    endtask

    task automatic driveInstr(input word_t pc, input logic inSlot);
        @(negedge clk);
        instrValid  = 1'b1;
        instrPc     = pc;
        instrInSlot = inSlot;
    endtask

    task automatic expectRedirect(input word_t target);
        @(negedge clk);
        clearPipeline();
        check("redirectValid", word_t'(redirectValid), 32'd1);
        check("redirectPc", redirectPc, target);
        @(negedge clk);
        check("redirectValid", word_t'(redirectValid), 32'd0);
    endtask

    task automatic expectNoRedirect();
        @(negedge clk);
        clearPipeline();
        check("redirectValid", word_t'(redirectValid), 32'd0);
        @(negedge clk);
        check("redirectValid", word_t'(redirectValid), 32'd0);
    endtask

    // ##########################################################################
    // Directed tests.
    // ##########################################################################
    task automatic resetValuesAndMasks();
        readExpect("Status", `CP0_STATUS, `STATUS_RESET);
        readExpect("Config", `CP0_CONFIG, `CONFIG_RESET);
        readExpect("Config1", `CP0_CONFIG1, `CONFIG1_RESET);
        readExpect("Cause", `CP0_CAUSE, 32'd0);
        readExpect("Index", `CP0_INDEX, 32'd0);
        wbWrite(`CP0_STATUS, '1);
        readExpect("Status", `CP0_STATUS, `STATUS_WMASK | `STATUS_RESET);
        wbWrite(`CP0_ENTRYHI, '1);
        readExpect("EntryHi", `CP0_ENTRYHI, `ENTRYHI_WMASK);
        wbWrite(`CP0_ENTRYLO0, '1);
        readExpect("EntryLo0", `CP0_ENTRYLO0, `ENTRYLO_WMASK);
        wbWrite(`CP0_INDEX, '1);
        readExpect("Index", `CP0_INDEX, `INDEX_WMASK);
        readExpect("Unmapped", 8'h08, 32'd0);  // Random is not implemented.
        wbWrite(`CP0_STATUS, 32'd0);
    endtask

    task automatic tlbWriteReadProbe();
        tlbIdx_t slots [3];
        word_t   hi;
        logic    g;
        slots[0] = 4'd3;
        slots[1] = 4'd7;
        slots[2] = 4'd12;
        for (int n = 0; n < 3; n++) begin
            hi = $random(seed);
            modelHi[n]  = (hi & 32'hFFFF_80FF) | (word_t'(n) << 13);  // Distinct VPN2.
            modelLo0[n] = $random(seed) & `ENTRYLO_WMASK;
            modelLo1[n] = $random(seed) & `ENTRYLO_WMASK;
            if (n == 2) begin
                modelLo0[n][0] = 1'b1;  // Global entry.
                modelLo1[n][0] = 1'b1;
            end else begin
                modelLo0[n][0] = 1'b0;
            end
            wbWrite(`CP0_INDEX, word_t'(slots[n]));
            wbWrite(`CP0_ENTRYHI, modelHi[n]);
            wbWrite(`CP0_ENTRYLO0, modelLo0[n]);
            wbWrite(`CP0_ENTRYLO1, modelLo1[n]);
            tlbOp(tlbWriteIndexed);
        end
        for (int n = 0; n < 3; n++) begin
            wbWrite(`CP0_ENTRYHI, 32'd0);
            wbWrite(`CP0_INDEX, word_t'(slots[n]));
            tlbOp(tlbRead);
            g = modelLo0[n][0] & modelLo1[n][0];
            readExpect("EntryHi", `CP0_ENTRYHI, modelHi[n]);
            readExpect("EntryLo0", `CP0_ENTRYLO0, {modelLo0[n][31:1], g});
            readExpect("EntryLo1", `CP0_ENTRYLO1, {modelLo1[n][31:1], g});
        end
        wbWrite(`CP0_ENTRYHI, modelHi[1]);
        tlbOp(tlbProbe);
        readExpect("Index", `CP0_INDEX, 32'd7);
        wbWrite(`CP0_ENTRYHI, modelHi[2] ^ 32'h0000_0055);  // Global ignores ASID.
        tlbOp(tlbProbe);
        readExpect("Index", `CP0_INDEX, 32'd12);
        wbWrite(`CP0_ENTRYHI, modelHi[1] ^ 32'h0000_0001);
        tlbOp(tlbProbe);
        readExpect("Index", `CP0_INDEX, 32'h8000_0000);
    endtask

    task automatic exceptionEntryAndEret();
        word_t bad;
        word_t pc;
        word_t value;
        bad = $random(seed);
        pc  = 32'h8000_2040;
        raiseExc(`EXC_TLBL, pc, 1'b1, 1'b1, bad);
        expectRedirect(`EXC_VECTOR);
        readExpect("EPC", `CP0_EPC, pc - 32'd4);
        wbRead(`CP0_CAUSE, value);
        check("Cause.BD/ExcCode", value & 32'h8000_007C, {1'b1, 24'd0, `EXC_TLBL, 2'b00});
        readExpect("BadVAddr", `CP0_BADVADDR, bad);
        wbRead(`CP0_ENTRYHI, value);
        check("EntryHi.VPN2", value & 32'hFFFF_E000, bad & 32'hFFFF_E000);
        readExpect("Status", `CP0_STATUS, `STATUS_RESET | 32'h2);
        raiseExc(`EXC_TLBS, pc + 32'd8, 1'b0, 1'b0, 32'd0);
        expectNoRedirect();  // EXL blocks a second entry.
        doEret();
        expectRedirect(pc - 32'd4);
        readExpect("Status", `CP0_STATUS, `STATUS_RESET);
    endtask

    task automatic interruptEntry();
        word_t value;
        wbWrite(`CP0_CAUSE, 32'h0000_0100);
        wbWrite(`CP0_STATUS, 32'h0000_0101);
        driveInstr(32'h8000_3000, 1'b0);
        expectRedirect(`EXC_VECTOR);
        wbRead(`CP0_CAUSE, value);
        check("Cause.BD/ExcCode", value & 32'h8000_007C, 32'd0);
        readExpect("EPC", `CP0_EPC, 32'h8000_3000);
        driveInstr(32'h8000_3004, 1'b0);
        expectNoRedirect();
        doEret();
        expectRedirect(32'h8000_3000);
        wbWrite(`CP0_STATUS, 32'h0000_0100);  // IE off.
        driveInstr(32'h8000_3008, 1'b0);
        expectNoRedirect();
        wbWrite(`CP0_CAUSE, 32'd0);
        wbWrite(`CP0_STATUS, 32'h0000_1001);  // IM4 for line 2.
        @(negedge clk);
        interrupt = 6'b00_0100;
        driveInstr(32'h8000_3100, 1'b1);
        expectRedirect(`EXC_VECTOR);
        wbRead(`CP0_CAUSE, value);
        check("Cause.IP/BD/ExcCode", value & 32'h8000_107C, 32'h8000_1000);
        readExpect("EPC", `CP0_EPC, 32'h8000_30FC);
        @(negedge clk);
        interrupt = '0;
        doEret();
        expectRedirect(32'h8000_30FC);
        wbWrite(`CP0_STATUS, 32'd0);
    endtask

    task automatic timerCompare();
        word_t value;
        word_t first;
        word_t second;
        wbWrite(`CP0_COUNT, 32'd0);
        wbWrite(`CP0_COMPARE, 32'd20);
        repeat (60) @(negedge clk);
        wbRead(`CP0_CAUSE, value);
        check("Cause.TI", {31'd0, value[30]}, 32'd1);
        wbWrite(`CP0_COMPARE, 32'h0100_0000);
        wbRead(`CP0_CAUSE, value);
        check("Cause.TI", {31'd0, value[30]}, 32'd0);
        wbRead(`CP0_COUNT, first);
        wbRead(`CP0_COUNT, second);
        check("Count increases", (second > first) ? 32'd1 : 32'd0, 32'd1);
    endtask

    // ##########################################################################
    // Main sequence and watchdog.
    // ##########################################################################
    initial begin
        seed      = 96643;
        clk       = 1'b0;
        rst       = 1'b1;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = '0;
        wbDatW    = '0;
        interrupt = '0;
        tlbCmd    = tlbNone;
        excCode   = '0;
        excPc     = '0;
        excBadVAddr = '0;
        instrPc   = '0;
        clearPipeline();
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        resetValuesAndMasks();
        tlbWriteReadProbe();
        exceptionEntryAndEret();
        interruptEntry();
        timerCompare();
        @(negedge clk);
        if (dut.sva.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("%0d assertion failures were seen", dut.sva.failCount);
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
        $display("Something failed");
        $fatal(1, "watchdog");
    end

endmodule

`default_nettype wire

//--- test/cp0_sva.sv
`default_nettype none

module cp0Sva (
    input logic clk,
    input logic rst,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic redirectValid
);

    int failCount = 0;

    // ##########################################################################
    // Wishbone handshake.
    // ##########################################################################
    ackOneCycle: assert property (@(posedge clk) disable iff (rst) wbAck |=> !wbAck)
        else begin
            $error("wbAck stayed high for more than one cycle");
            failCount++;
        end

    ackAfterRequest: assert property (@(posedge clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb && !wbAck))
        else begin
            $error("wbAck rose without a new request");
            failCount++;
        end

    // ##########################################################################
    // Redirect pulse and reset state.
    // ##########################################################################
    redirectOneCycle: assert property (@(posedge clk) disable iff (rst)
        redirectValid |=> !redirectValid)
        else begin
            $error("redirectValid lasted two cycles");
            failCount++;
        end

    quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbAck && !redirectValid)
        else begin
            $error("wbAck or redirectValid high right after reset");
            failCount++;
        end

endmodule

bind cp0Subsystem cp0Sva sva (.*);

`default_nettype wire
